//--- eth_demux_ctrl.sv
/* frame FSM of the switch, accepts one header at a time and latches its port
   then passes payload beats into the payload skid until the last beat is taken */
`timescale 1ns/100ps

module eth_demux_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    eth_stream_if.snk                in_s,
    input  logic                     enable,
    input  eth_switch_pkg::port_t    cls_port,
    output logic                     hdr_push_valid,
    input  logic                     hdr_push_ready,
    output eth_switch_pkg::eth_hdr_t hdr_push_data,
    output logic                     beat_push_valid,
    input  logic                     beat_push_ready,
    output eth_switch_pkg::beat_t    beat_push_data,
    input  logic                     hdr_pend,
    input  logic                     beat_pend,
    output eth_switch_pkg::port_t    sel
);
    import eth_switch_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_FRAME
    } state_t;

    state_t state;
    logic   in_frame;
    logic   hdr_take;
    logic   beat_take;

    assign in_frame = (state == ST_FRAME);

    // start a frame only when both skids have drained the previous one,
    // so the port can change without stranding any beat
    assign hdr_take = enable & in_s.hdr_valid & ~in_frame & hdr_push_ready
                      & ~hdr_pend & ~beat_pend;

    assign in_s.hdr_ready = hdr_take;
    assign hdr_push_valid = hdr_take;
    assign hdr_push_data  = in_s.hdr;

    // payload flows only inside a frame
    assign in_s.tready     = in_frame & beat_push_ready;
    assign beat_push_valid = in_frame & in_s.tvalid;
    assign beat_take       = beat_push_valid & beat_push_ready;
    assign beat_push_data  = '{tdata: in_s.tdata, tlast: in_s.tlast, tuser: in_s.tuser};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            sel   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_take) begin
                        state <= ST_FRAME;
                        sel   <= cls_port;
                    end
                end
                ST_FRAME: begin
                    // frame ends on the accepted last beat
                    if (beat_take && in_s.tlast) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // an accepted header sits on the header skid output one cycle later
    a_hdr_in_skid: assert property (
        @(posedge clk) disable iff (rst)
        hdr_push_valid |=> hdr_pend
    ) else $error("accepted header missing from the header skid output");

    // port must hold for the whole frame, including the cycle after the last beat
    a_sel_hold: assert property (
        @(posedge clk) disable iff (rst)
        in_frame |=> $stable(sel)
    ) else $error("port select changed inside a frame");

endmodule

//--- eth_port_fanout.sv
/* steers the buffered header and payload to the latched output port
   data fans out to every port, valids go only to sel, readies come back from sel */
`timescale 1ns/100ps

module eth_port_fanout (
    input  eth_switch_pkg::port_t    sel,
    input  logic                     hdr_valid,
    output logic                     hdr_ready,
    input  eth_switch_pkg::eth_hdr_t hdr,
    input  logic                     beat_valid,
    output logic                     beat_ready,
    input  eth_switch_pkg::beat_t    beat,
    eth_stream_if.src                out_s [eth_switch_pkg::NUM_PORTS]
);
    import eth_switch_pkg::*;

    logic [NUM_PORTS-1:0] hv;
    logic [NUM_PORTS-1:0] tv;
    logic [NUM_PORTS-1:0] hr;
    logic [NUM_PORTS-1:0] tr;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        // data is shared, only the valids are steered
        assign out_s[i].hdr   = hdr;
        assign out_s[i].tdata = beat.tdata;
        assign out_s[i].tlast = beat.tlast;
        assign out_s[i].tuser = beat.tuser;

        assign hv[i] = hdr_valid & (sel == port_t'(i));
        assign tv[i] = beat_valid & (sel == port_t'(i));

        assign out_s[i].hdr_valid = hv[i];
        assign out_s[i].tvalid    = tv[i];

        assign hr[i] = out_s[i].hdr_ready;
        assign tr[i] = out_s[i].tready;
    end

    assign hdr_ready  = hr[sel];
    assign beat_ready = tr[sel];

endmodule

//--- eth_skid_reg.sv
/* one-stage valid/ready register with a skid slot, T is the payload type
   in_ready is registered, so out_ready never reaches the upstream combinationally */
`timescale 1ns/100ps

module eth_skid_reg #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    T     temp_data;
    logic temp_valid;
    logic in_take;
    logic ready_early;

    assign in_take = in_valid & in_ready;

    // stay ready if the output drains this cycle, or the skid slot will still be free
    assign ready_early = out_ready | (~temp_valid & (~out_valid | ~in_take));

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready   <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            in_ready <= ready_early;
            if (in_ready) begin
                if (out_ready || !out_valid) begin
                    out_valid <= in_valid;
                end else begin
                    // output stalled, park the beat in flight
                    temp_valid <= in_valid;
                end
            end else if (out_ready) begin
                out_valid  <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                out_data <= in_data;
            end else begin
                temp_data <= in_data;
            end
        end else if (out_ready) begin
            out_data <= temp_data;
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("skid output changed while stalled");

endmodule

//--- eth_stream_if.sv
/* one ethernet stream: a header channel and an 8-bit payload channel
   src is the producer side, snk the consumer side */
`timescale 1ns/100ps

interface eth_stream_if;
    import eth_switch_pkg::*;

    // header channel
    logic     hdr_valid;
    logic     hdr_ready;
    eth_hdr_t hdr;

    // payload channel
    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;
    logic       tuser;

    modport src (
        output hdr_valid, hdr, tdata, tvalid, tlast, tuser,
        input  hdr_ready, tready
    );

    modport snk (
        input  hdr_valid, hdr, tdata, tvalid, tlast, tuser,
        output hdr_ready, tready
    );

endinterface

//--- eth_switch_pkg.sv
/* shared types and constants for the EtherType frame switch
   imported by the interface and by every RTL block that handles headers or beats */
package eth_switch_pkg;

    // fixed number of output ports
    localparam int NUM_PORTS = 4;

    // output port index
    typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

    // EtherType values with a dedicated port
    localparam logic [15:0] ETYPE_IPV4 = 16'h0800;
    localparam logic [15:0] ETYPE_ARP  = 16'h0806;
    localparam logic [15:0] ETYPE_IPV6 = 16'h86dd;

    // ethernet header, 112 bits
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one payload byte with its frame flags
    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
        logic       tuser;
    } beat_t;

endpackage

//--- eth_switch_stim.txt
# etype dest_mac src_mac len first_byte user en_hold ready_pct
# values are hex except len, user, en_hold and ready_pct which are decimal
0800 0a1b2c3d4e5f 112233445566 12 00 1 0 100
0806 ffffffffffff 020000000001 6 40 0 3 60
86dd 333300000001 020000000002 20 80 1 0 40
88cc 0180c200000e 020000000003 9 f0 1 5 100
0800 0a1b2c3d4e5f 020000000004 3 10 0 0 25
86dd 333300000002 020000000005 1 55 1 2 70
0806 ffffffffffff 020000000006 16 a0 1 0 100
9000 0123456789ab 020000000007 30 fe 0 8 50
0800 0a1b2c3d4e5f 020000000008 25 20 1 0 80
88f7 011b19000000 020000000009 7 c8 1 4 30

//--- eth_type_classify.sv
/* routing policy of the switch, maps a header's EtherType to an output port
   purely combinational, feeds the port choice to the frame control */
`timescale 1ns/100ps

module eth_type_classify (
    input  eth_switch_pkg::eth_hdr_t hdr,
    output eth_switch_pkg::port_t    port
);
    import eth_switch_pkg::*;

    always_comb begin
        case (hdr.eth_type)
            ETYPE_IPV4: begin
                port = port_t'(0);
            end
            ETYPE_ARP: begin
                port = port_t'(1);
            end
            ETYPE_IPV6: begin
                port = port_t'(2);
            end
            // everything else lands on the last port
            default: begin
                port = port_t'(NUM_PORTS - 1);
            end
        endcase
    end

endmodule

//--- eth_type_switch.sv
/* EtherType frame switch, one input stream routed to one of four outputs
   top level with plain ports, maps them onto the internal stream interfaces */
`timescale 1ns/100ps

module eth_type_switch (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        in_hdr_valid,
    output logic        in_hdr_ready,
    input  logic [47:0] in_dest_mac,
    input  logic [47:0] in_src_mac,
    input  logic [15:0] in_eth_type,
    input  logic [7:0]  in_tdata,
    input  logic        in_tvalid,
    output logic        in_tready,
    input  logic        in_tlast,
    input  logic        in_tuser,
    output logic        out0_hdr_valid,
    input  logic        out0_hdr_ready,
    output logic [47:0] out0_dest_mac,
    output logic [47:0] out0_src_mac,
    output logic [15:0] out0_eth_type,
    output logic [7:0]  out0_tdata,
    output logic        out0_tvalid,
    input  logic        out0_tready,
    output logic        out0_tlast,
    output logic        out0_tuser,
    output logic        out1_hdr_valid,
    input  logic        out1_hdr_ready,
    output logic [47:0] out1_dest_mac,
    output logic [47:0] out1_src_mac,
    output logic [15:0] out1_eth_type,
    output logic [7:0]  out1_tdata,
    output logic        out1_tvalid,
    input  logic        out1_tready,
    output logic        out1_tlast,
    output logic        out1_tuser,
    output logic        out2_hdr_valid,
    input  logic        out2_hdr_ready,
    output logic [47:0] out2_dest_mac,
    output logic [47:0] out2_src_mac,
    output logic [15:0] out2_eth_type,
    output logic [7:0]  out2_tdata,
    output logic        out2_tvalid,
    input  logic        out2_tready,
    output logic        out2_tlast,
    output logic        out2_tuser,
    output logic        out3_hdr_valid,
    input  logic        out3_hdr_ready,
    output logic [47:0] out3_dest_mac,
    output logic [47:0] out3_src_mac,
    output logic [15:0] out3_eth_type,
    output logic [7:0]  out3_tdata,
    output logic        out3_tvalid,
    input  logic        out3_tready,
    output logic        out3_tlast,
    output logic        out3_tuser
);
    import eth_switch_pkg::*;

    eth_stream_if in_s ();
    eth_stream_if out_s [NUM_PORTS] ();

    port_t    cls_port;
    port_t    sel;
    logic     hdr_push_valid;
    logic     hdr_push_ready;
    eth_hdr_t hdr_push_data;
    logic     beat_push_valid;
    logic     beat_push_ready;
    beat_t    beat_push_data;
    logic     hdr_out_valid;
    logic     hdr_out_ready;
    eth_hdr_t hdr_out_data;
    logic     beat_out_valid;
    logic     beat_out_ready;
    beat_t    beat_out_data;

    // input side
    assign in_s.hdr_valid = in_hdr_valid;
    assign in_hdr_ready   = in_s.hdr_ready;
    assign in_s.hdr       = '{dest_mac: in_dest_mac, src_mac: in_src_mac, eth_type: in_eth_type};
    assign in_s.tdata     = in_tdata;
    assign in_s.tvalid    = in_tvalid;
    assign in_tready      = in_s.tready;
    assign in_s.tlast     = in_tlast;
    assign in_s.tuser     = in_tuser;

    // output ports
    assign out0_hdr_valid     = out_s[0].hdr_valid;
    assign out_s[0].hdr_ready = out0_hdr_ready;
    assign out0_dest_mac      = out_s[0].hdr.dest_mac;
    assign out0_src_mac       = out_s[0].hdr.src_mac;
    assign out0_eth_type      = out_s[0].hdr.eth_type;
    assign out0_tdata         = out_s[0].tdata;
    assign out0_tvalid        = out_s[0].tvalid;
    assign out_s[0].tready    = out0_tready;
    assign out0_tlast         = out_s[0].tlast;
    assign out0_tuser         = out_s[0].tuser;

    assign out1_hdr_valid     = out_s[1].hdr_valid;
    assign out_s[1].hdr_ready = out1_hdr_ready;
    assign out1_dest_mac      = out_s[1].hdr.dest_mac;
    assign out1_src_mac       = out_s[1].hdr.src_mac;
    assign out1_eth_type      = out_s[1].hdr.eth_type;
    assign out1_tdata         = out_s[1].tdata;
    assign out1_tvalid        = out_s[1].tvalid;
    assign out_s[1].tready    = out1_tready;
    assign out1_tlast         = out_s[1].tlast;
    assign out1_tuser         = out_s[1].tuser;

    assign out2_hdr_valid     = out_s[2].hdr_valid;
    assign out_s[2].hdr_ready = out2_hdr_ready;
    assign out2_dest_mac      = out_s[2].hdr.dest_mac;
    assign out2_src_mac       = out_s[2].hdr.src_mac;
    assign out2_eth_type      = out_s[2].hdr.eth_type;
    assign out2_tdata         = out_s[2].tdata;
    assign out2_tvalid        = out_s[2].tvalid;
    assign out_s[2].tready    = out2_tready;
    assign out2_tlast         = out_s[2].tlast;
    assign out2_tuser         = out_s[2].tuser;

    assign out3_hdr_valid     = out_s[3].hdr_valid;
    assign out_s[3].hdr_ready = out3_hdr_ready;
    assign out3_dest_mac      = out_s[3].hdr.dest_mac;
    assign out3_src_mac       = out_s[3].hdr.src_mac;
    assign out3_eth_type      = out_s[3].hdr.eth_type;
    assign out3_tdata         = out_s[3].tdata;
    assign out3_tvalid        = out_s[3].tvalid;
    assign out_s[3].tready    = out3_tready;
    assign out3_tlast         = out_s[3].tlast;
    assign out3_tuser         = out_s[3].tuser;

    eth_type_classify u_classify (
        .hdr  (in_s.hdr),
        .port (cls_port)
    );

    eth_demux_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .in_s            (in_s.snk),
        .enable          (enable),
        .cls_port        (cls_port),
        .hdr_push_valid  (hdr_push_valid),
        .hdr_push_ready  (hdr_push_ready),
        .hdr_push_data   (hdr_push_data),
        .beat_push_valid (beat_push_valid),
        .beat_push_ready (beat_push_ready),
        .beat_push_data  (beat_push_data),
        .hdr_pend        (hdr_out_valid),
        .beat_pend       (beat_out_valid),
        .sel             (sel)
    );

    eth_skid_reg #(.T(eth_hdr_t)) hdr_skid (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (hdr_push_valid),
        .in_ready  (hdr_push_ready),
        .in_data   (hdr_push_data),
        .out_valid (hdr_out_valid),
        .out_ready (hdr_out_ready),
        .out_data  (hdr_out_data)
    );

    eth_skid_reg #(.T(beat_t)) beat_skid (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (beat_push_valid),
        .in_ready  (beat_push_ready),
        .in_data   (beat_push_data),
        .out_valid (beat_out_valid),
        .out_ready (beat_out_ready),
        .out_data  (beat_out_data)
    );

    eth_port_fanout u_fanout (
        .sel        (sel),
        .hdr_valid  (hdr_out_valid),
        .hdr_ready  (hdr_out_ready),
        .hdr        (hdr_out_data),
        .beat_valid (beat_out_valid),
        .beat_ready (beat_out_ready),
        .beat       (beat_out_data),
        .out_s      (out_s)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the switch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_eth_type_switch -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_eth_type_switch.sv
/* testbench for the EtherType switch, reads frames from eth_switch_stim.txt
   drives the input stream, predicts routing and checks all four outputs */
`timescale 1ns/100ps

module tb_eth_type_switch;
    logic        clk, rst, enable;
    logic        in_hdr_valid, in_hdr_ready, in_tvalid, in_tready, in_tlast, in_tuser;
    logic [47:0] in_dest_mac, in_src_mac;
    logic [15:0] in_eth_type;
    logic [7:0]  in_tdata;
    logic [3:0]  hv, tv, hr, tr;
    logic [111:0] hw [4];
    logic [9:0]  bw [4];
    logic [47:0] od [4], os [4];
    logic [15:0] ot [4];
    logic [7:0]  otd [4];
    logic [3:0]  otl, otu;

    logic [15:0] f_type [32];
    logic [47:0] f_dst [32], f_src [32];
    logic [7:0]  f_first [32];
    int          f_len [32], f_user [32], f_hold [32], f_pct [32];
    int          nframes, limit, cyc, errors, tests_pass, tests_fail, err_mark;
    int          hdr_seen, done_frames, beat_idx, last_beat_cyc;
    logic        prev_en, prev_any_hv;
    logic [113:0] hdr_q [$];
    logic [11:0] beat_q [$];

    eth_type_switch dut (
        .clk(clk), .rst(rst), .enable(enable),
        .in_hdr_valid(in_hdr_valid), .in_hdr_ready(in_hdr_ready),
        .in_dest_mac(in_dest_mac), .in_src_mac(in_src_mac), .in_eth_type(in_eth_type),
        .in_tdata(in_tdata), .in_tvalid(in_tvalid), .in_tready(in_tready),
        .in_tlast(in_tlast), .in_tuser(in_tuser),
        .out0_hdr_valid(hv[0]), .out0_hdr_ready(hr[0]), .out0_dest_mac(od[0]),
        .out0_src_mac(os[0]), .out0_eth_type(ot[0]), .out0_tdata(otd[0]),
        .out0_tvalid(tv[0]), .out0_tready(tr[0]), .out0_tlast(otl[0]), .out0_tuser(otu[0]),
        .out1_hdr_valid(hv[1]), .out1_hdr_ready(hr[1]), .out1_dest_mac(od[1]),
        .out1_src_mac(os[1]), .out1_eth_type(ot[1]), .out1_tdata(otd[1]),
        .out1_tvalid(tv[1]), .out1_tready(tr[1]), .out1_tlast(otl[1]), .out1_tuser(otu[1]),
        .out2_hdr_valid(hv[2]), .out2_hdr_ready(hr[2]), .out2_dest_mac(od[2]),
        .out2_src_mac(os[2]), .out2_eth_type(ot[2]), .out2_tdata(otd[2]),
        .out2_tvalid(tv[2]), .out2_tready(tr[2]), .out2_tlast(otl[2]), .out2_tuser(otu[2]),
        .out3_hdr_valid(hv[3]), .out3_hdr_ready(hr[3]), .out3_dest_mac(od[3]),
        .out3_src_mac(os[3]), .out3_eth_type(ot[3]), .out3_tdata(otd[3]),
        .out3_tvalid(tv[3]), .out3_tready(tr[3]), .out3_tlast(otl[3]), .out3_tuser(otu[3])
    );

    for (genvar p = 0; p < 4; p++) begin : g_mon
        assign hw[p] = {od[p], os[p], ot[p]};
        assign bw[p] = {otd[p], otl[p], otu[p]};
    end

    // expected output port for an EtherType
    function automatic logic [1:0] route(input logic [15:0] et);
        if (et == 16'h0800) return 2'd0;
        if (et == 16'h0806) return 2'd1;
        if (et == 16'h86dd) return 2'd2;
        return 2'd3;
    endfunction

    task automatic expect_true(input bit cond, input string msg);
        assert (cond) else begin
            $display("[ERROR] %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        if (errors == err_mark) begin
            tests_pass++;
            $display("test %s: pass", name);
        end else begin
            tests_fail++;
            $display("test %s: FAIL", name);
        end
        err_mark = errors;
    endtask

    task automatic load_stim(output bit ok);
        int    fd;
        string line;
        nframes = 0;
        limit = 500;
        fd = $fopen("eth_switch_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && nframes < 32) begin
                if ($fgets(line, fd) > 8 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h %d %h %d %d %d", f_type[nframes],
                            f_dst[nframes], f_src[nframes], f_len[nframes],
                            f_first[nframes], f_user[nframes], f_hold[nframes],
                            f_pct[nframes]) == 8) begin
                        limit += 20 * f_len[nframes];
                        nframes++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic all_idle(input string when);
        expect_true(!in_hdr_ready && !in_tready && hv == 4'b0 && tv == 4'b0,
                    {"ready or valid high ", when});
    endtask

    task automatic send_frame(input int i);
        logic [1:0] port;
        bit dense;
        bit done;
        port = route(f_type[i]);
        dense = (f_pct[i] == 100);
        hdr_q.push_back({port, f_dst[i], f_src[i], f_type[i]});
        for (int b = 0; b < f_len[i]; b++) begin
            beat_q.push_back({port, 8'(f_first[i] + b), b == f_len[i] - 1,
                              f_user[i] != 0 && b == f_len[i] - 1});
        end
        in_dest_mac = f_dst[i];
        in_src_mac = f_src[i];
        in_eth_type = f_type[i];
        if (f_hold[i] > 0) begin
            // header already waits at the input while enable is low
            in_hdr_valid = 1'b1;
            enable = 1'b0;
            repeat (f_hold[i]) @(negedge clk);
        end
        enable = 1'b1;
        done = 0;
        while (!done) begin
            if (!in_hdr_valid) in_hdr_valid = ($urandom % 3 != 0);
            #1;
            done = in_hdr_valid && in_hdr_ready;
            @(negedge clk);
        end
        in_hdr_valid = 1'b0;
        for (int b = 0; b < f_len[i]; b++) begin
            in_tdata = 8'(f_first[i] + b);
            in_tlast = (b == f_len[i] - 1);
            in_tuser = (f_user[i] != 0) && (b == f_len[i] - 1);
            in_tvalid = dense || ($urandom % 4 != 0);
            done = 0;
            while (!done) begin
                #1;
                done = in_tvalid && in_tready;
                @(negedge clk);
                if (!done && !in_tvalid) in_tvalid = ($urandom % 4 != 0);
            end
        end
        in_tvalid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // output readies follow the probability of the frame now at the outputs
    initial begin
        int pct;
        hr = '0;
        tr = '0;
        forever begin
            @(negedge clk);
            pct = f_pct[done_frames];
            for (int p = 0; p < 4; p++) begin
                hr[p] = (pct >= 100) || ($urandom_range(99) < pct);
                tr[p] = (pct >= 100) || ($urandom_range(99) < pct);
            end
        end
    end

    always @(posedge clk) begin
        logic [113:0] eh;
        logic [11:0]  eb;
        if (!rst) begin
            if (!enable) expect_true(!in_hdr_ready, "in_hdr_ready high while enable low");
            if (|hv && !prev_any_hv) expect_true(prev_en, "header appeared after enable low");
            for (int p = 0; p < 4; p++) begin
                if (hv[p] && hr[p]) begin
                    expect_true(hdr_q.size() > 0, "header with no frame expected");
                    expect_true(hdr_seen <= done_frames, "header before previous frame ended");
                    if (hdr_q.size() > 0) begin
                        eh = hdr_q.pop_front();
                        expect_true(eh[113:112] == 2'(p), "header on the wrong port");
                        expect_true(eh[111:0] == hw[p], "header fields differ");
                    end
                    hdr_seen++;
                end
                if (tv[p] && tr[p]) begin
                    expect_true(beat_q.size() > 0, "beat with no frame expected");
                    if (f_pct[done_frames] == 100 && beat_idx > 0)
                        expect_true(cyc == last_beat_cyc + 1, "bubble at full readiness");
                    last_beat_cyc = cyc;
                    beat_idx++;
                    if (beat_q.size() > 0) begin
                        eb = beat_q.pop_front();
                        expect_true(eb[11:10] == 2'(p), "beat on the wrong port");
                        expect_true(eb[9:0] == bw[p], "beat data or flags differ");
                    end
                    if (otl[p]) begin
                        test_done($sformatf("frame %0d port %0d", done_frames, p));
                        done_frames++;
                        beat_idx = 0;
                    end
                end
            end
        end
        prev_en = enable;
        prev_any_hv = |hv;
        cyc++;
        if (cyc > limit) begin
            $display("timeout: not every frame arrived within %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        bit stim_ok;
        // valids and enable stay high during reset, the DUT must refuse them
        {rst, enable, in_hdr_valid, in_tvalid, in_tlast, in_tuser} = 6'b111100;
        {in_dest_mac, in_src_mac, in_eth_type, in_tdata} = '0;
        {errors, tests_pass, tests_fail, err_mark, cyc} = '0;
        {hdr_seen, done_frames, beat_idx, last_beat_cyc} = '0;
        prev_en = 1'b0;
        prev_any_hv = 1'b0;
        void'($urandom(32'h141e));
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("could not open the stimulus file eth_switch_stim.txt");
            $display("Checks failed");
            $finish;
        end else begin
            for (int c = 0; c < 10; c++) begin
                @(negedge clk);
                if (c > 0) all_idle("during reset");
            end
            {enable, in_hdr_valid, in_tvalid} = 3'b000;
            rst = 1'b0;
            @(negedge clk);
            all_idle("after reset");
            test_done("reset");
            for (int i = 0; i < nframes; i++) send_frame(i);
            while (done_frames < nframes || hdr_seen < nframes) @(negedge clk);
            expect_true(hdr_q.size() == 0 && beat_q.size() == 0, "expected data left over");
            $display("tests passed %0d failed %0d, errors %0d", tests_pass, tests_fail, errors);
            if (errors == 0 && tests_fail == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

//--- vlog.f
eth_switch_pkg.sv
eth_stream_if.sv
eth_type_classify.sv
eth_demux_ctrl.sv
eth_skid_reg.sv
eth_port_fanout.sv
eth_type_switch.sv
tb_eth_type_switch.sv
